// ==== cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath width
`define XLEN 32

// Memory depths in words
`define IMEM_WORDS 64
`define DMEM_WORDS 64

// Major opcodes of the supported subset
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011

// funct3 codes
`define F3_ADD 3'b000 // Also SUB, ADDI and BEQ
`define F3_SLT 3'b010
`define F3_OR  3'b110
`define F3_AND 3'b111

`endif

// ==== cpuPkg.sv ====
`include "cpu_consts.svh"

package cpuPkg;

    // Data and address word
    typedef logic [`XLEN-1:0] word_t;

    // Raw instruction word
    typedef logic [31:0] inst_t;

    typedef logic [4:0] regIdx_t; // x0 to x31

    // Word index into instruction memory
    typedef logic [$clog2(`IMEM_WORDS)-1:0] imemAddr_t;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOp_t;

endpackage

// ==== fetchUnit.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module fetchUnit (
    input  logic              CLK,
    input  logic              rstN,
    input  logic              run,
    input  logic              imemWe,
    input  cpuPkg::imemAddr_t imemAddr,
    input  cpuPkg::inst_t     imemData,
    input  logic              branch,
    input  logic              zero,
    input  cpuPkg::word_t     branchTarget,
    output cpuPkg::word_t     pc,
    output cpuPkg::inst_t     inst
);
    import cpuPkg::*;

    inst_t     imem [`IMEM_WORDS];
    imemAddr_t pcIdx;
    word_t     pcPlus4;
    word_t     pcNext;

    // Program load port
    always_ff @(posedge CLK) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    assign pcIdx = pc[$bits(imemAddr_t)+1:2]; // Word index, low bits dropped
    assign inst  = imem[pcIdx];

    assign pcPlus4 = pc + word_t'(4);
    assign pcNext  = (branch && zero) ? branchTarget : pcPlus4; // Taken BEQ

    // Held at zero until run goes high
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// ==== decodeUnit.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module decodeUnit (
    input  logic            CLK,
    input  logic            rstN,
    input  logic            run,
    input  cpuPkg::inst_t   inst,
    input  cpuPkg::word_t   wbData,
    input  cpuPkg::regIdx_t dbgReg,
    output cpuPkg::word_t   rs1Data,
    output cpuPkg::word_t   rs2Data,
    output cpuPkg::word_t   imm,
    output cpuPkg::word_t   dbgData,
    output cpuPkg::aluOp_t  aluOp,
    output logic            aluSrc,
    output logic            memWrite,
    output logic            memToReg,
    output logic            regWrite,
    output logic            branch
);
    import cpuPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    regIdx_t    rs1;
    regIdx_t    rs2;
    regIdx_t    rd;
    word_t      regs [32];

    assign opcode   = inst[6:0];
    assign rd       = inst[11:7];
    assign funct3   = inst[14:12];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];
    assign funct7b5 = inst[30]; // Selects SUB in R-type

    // Main control, anything unknown falls through as a no-op
    always_comb begin
        aluOp    = ALU_ADD;
        aluSrc   = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        regWrite = 1'b0;
        branch   = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                regWrite = 1'b1;
                case (funct3)
                    `F3_ADD: aluOp = funct7b5 ? ALU_SUB : ALU_ADD;
                    `F3_SLT: aluOp = ALU_SLT;
                    `F3_OR:  aluOp = ALU_OR;
                    `F3_AND: aluOp = ALU_AND;
                    default: regWrite = 1'b0; // Shifts and XOR unsupported
                endcase
            end
            `OP_ITYPE: begin
                aluSrc   = 1'b1;
                regWrite = (funct3 == `F3_ADD); // ADDI only
            end
            `OP_LOAD: begin
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            `OP_STORE: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            `OP_BRANCH: begin
                aluOp  = ALU_SUB; // Equal operands give zero
                branch = (funct3 == `F3_ADD); // BEQ only
            end
            default: ;
        endcase
    end

    // Immediate forms, all sign extended
    always_comb begin
        case (opcode)
            `OP_STORE:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            `OP_BRANCH: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                               inst[11:8], 1'b0};
            default:    imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

    // Register file, x0 is never written
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && run && rd != '0) begin
            regs[rd] <= wbData;
        end
    end

    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];
    assign dbgData = (dbgReg == '0) ? '0 : regs[dbgReg]; // Debug port

endmodule

// ==== executeUnit.sv ====
`timescale 1ns/100ps

module executeUnit (
    input  cpuPkg::word_t  rs1Data,
    input  cpuPkg::word_t  rs2Data,
    input  cpuPkg::word_t  imm,
    input  cpuPkg::word_t  pc,
    input  cpuPkg::aluOp_t aluOp,
    input  logic           aluSrc,
    output cpuPkg::word_t  aluResult,
    output cpuPkg::word_t  branchTarget,
    output logic           zero
);
    import cpuPkg::*;

    word_t operandB;

    // Immediate for ADDI, LW and SW
    assign operandB = aluSrc ? imm : rs2Data;

    always_comb begin
        case (aluOp)
            ALU_ADD: aluResult = rs1Data + operandB;
            ALU_SUB: aluResult = rs1Data - operandB;
            ALU_AND: aluResult = rs1Data & operandB;
            ALU_OR:  aluResult = rs1Data | operandB;
            ALU_SLT: begin
                // Signed compare, result in bit 0
                aluResult = word_t'($signed(rs1Data) < $signed(operandB));
            end
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // Immediate already carries the shift by one
    assign branchTarget = pc + imm;

endmodule

// ==== resultUnit.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module resultUnit (
    input  logic          CLK,
    input  logic          run,
    input  cpuPkg::word_t aluResult,
    input  cpuPkg::word_t rs2Data,
    input  logic          memWrite,
    input  logic          memToReg,
    output cpuPkg::word_t wbData
);
    import cpuPkg::*;

    localparam int IdxW = $clog2(`DMEM_WORDS);

    word_t            dmem [`DMEM_WORDS];
    logic [IdxW-1:0]  dmemIdx;
    word_t            loadData;

    // Word addressed, byte offset ignored
    assign dmemIdx = aluResult[IdxW+1:2];

    // SW
    always_ff @(posedge CLK) begin
        if (memWrite && run) begin
            dmem[dmemIdx] <= rs2Data;
        end
    end

    assign loadData = dmem[dmemIdx]; // Asynchronous read

    // Write-back source
    assign wbData = memToReg ? loadData : aluResult;

endmodule

// ==== singleCpu.sv ====
`timescale 1ns/100ps

module singleCpu (
    input  logic              CLK,
    input  logic              rstN,
    input  logic              run,
    input  logic              imemWe,
    input  cpuPkg::imemAddr_t imemAddr,
    input  cpuPkg::inst_t     imemData,
    input  cpuPkg::regIdx_t   dbgReg,
    output cpuPkg::word_t     dbgData,
    output cpuPkg::inst_t     OUT
);
    import cpuPkg::*;

    inst_t  inst;
    word_t  pc;
    word_t  rs1Data;
    word_t  rs2Data;
    word_t  imm;
    aluOp_t aluOp;
    logic   aluSrc;
    logic   memWrite;
    logic   memToReg;
    logic   branch;
    word_t  aluResult;
    word_t  branchTarget;
    logic   zero;
    word_t  wbData;

    assign OUT = inst; // Current instruction

    fetchUnit fetchUnit0 (
        .CLK(CLK), .rstN(rstN), .run(run),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .branch(branch), .zero(zero), .branchTarget(branchTarget),
        .pc(pc), .inst(inst)
    );

    decodeUnit decodeUnit0 (
        .CLK(CLK), .rstN(rstN), .run(run),
        .inst(inst), .wbData(wbData), .dbgReg(dbgReg),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .dbgData(dbgData),
        .aluOp(aluOp), .aluSrc(aluSrc), .memWrite(memWrite),
        .memToReg(memToReg), .regWrite(), .branch(branch)
    );

    executeUnit executeUnit0 (
        .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .pc(pc),
        .aluOp(aluOp), .aluSrc(aluSrc),
        .aluResult(aluResult), .branchTarget(branchTarget), .zero(zero)
    );

    resultUnit resultUnit0 (
        .CLK(CLK), .run(run),
        .aluResult(aluResult), .rs2Data(rs2Data),
        .memWrite(memWrite), .memToReg(memToReg),
        .wbData(wbData)
    );

endmodule

// ==== tbClock.sv ====
`timescale 1ns/100ps

module tbClock (
    output logic CLK
);

    // 10 ns period, low for the first half
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

endmodule

// ==== tbChecker.sv ====
`timescale 1ns/100ps

module tbChecker (
    input  logic          CLK,
    input  logic          run,
    input  cpuPkg::inst_t OUT,
    input  cpuPkg::word_t dbgData,
    input  cpuPkg::inst_t loopWord,
    input  logic          checkReq,
    input  logic [127:0]  checkName,
    input  cpuPkg::word_t checkExp,
    output int            passCount,
    output int            failCount
);
    import cpuPkg::*;

    int    passes = 0;
    int    fails = 0;
    inst_t lastOut = '0;
    logic  rowOk;

    // Drops the zero bytes in front of a short name
    function automatic string nameText(input logic [127:0] raw);
        string      s;
        logic [7:0] c;
        s = "";
        for (int i = 15; i >= 0; i--) begin
            c = raw[i*8 +: 8];
            if (c != 8'h00) begin
                s = $sformatf("%s%c", s, c);
            end
        end
        return s;
    endfunction

    // Instruction seen on the last running edge
    always @(posedge CLK) begin
        if (run) begin
            lastOut <= OUT;
        end
    end

    // Run is low here, so the register file is frozen
    always @(posedge CLK) begin
        if (checkReq) begin
            rowOk = 1'b1;
            if (dbgData !== checkExp) begin
                $display("FAIL %s: register expected %h, actual %h",
                         nameText(checkName), checkExp, dbgData);
                rowOk = 1'b0;
            end
            if (lastOut !== loopWord) begin // Program must end parked on its self-loop
                $display("FAIL %s: OUT expected %h, actual %h",
                         nameText(checkName), loopWord, lastOut);
                rowOk = 1'b0;
            end
            if (rowOk) begin
                passes++;
                $display("ok   %s: %h", nameText(checkName), dbgData);
            end else begin
                fails++;
            end
        end
    end

    assign passCount = passes;
    assign failCount = fails;

endmodule

// ==== tbSingleCpu.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module tbSingleCpu;
    import cpuPkg::*;

    localparam int    MaxRows  = 16;
    localparam int    MaxWords = 8;
    localparam inst_t LoopWord = 32'h0000_0063; // BEQ x0, x0, 0

    logic      CLK;
    logic      rstN;
    logic      run;
    logic      imemWe;
    imemAddr_t imemAddr;
    inst_t     imemData;
    regIdx_t   dbgReg;
    word_t     dbgData;
    inst_t     OUT;

    logic         checkReq;
    logic [127:0] checkName;
    word_t        checkExp;
    int           passCount;
    int           failCount;

    // Test table
    logic [127:0] rowName [MaxRows];
    inst_t        rowProg [MaxRows][MaxWords];
    int           rowLen [MaxRows];
    regIdx_t      rowReg [MaxRows];
    word_t        rowExp [MaxRows];
    int           rowRun [MaxRows];
    int           numRows;

    inst_t       prog [MaxWords]; // Program being assembled
    int          progLen;
    logic [31:0] lcgState;
    int          cycleCount = 0;
    int          cycleLimit;

    tbClock tbClock0 (.CLK(CLK));

    singleCpu dut0 (
        .CLK(CLK), .rstN(rstN), .run(run),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .dbgReg(dbgReg), .dbgData(dbgData), .OUT(OUT)
    );

    tbChecker tbChecker0 (
        .CLK(CLK), .run(run), .OUT(OUT), .dbgData(dbgData), .loopWord(LoopWord),
        .checkReq(checkReq), .checkName(checkName), .checkExp(checkExp),
        .passCount(passCount), .failCount(failCount)
    );

    // 11-bit signed value from the middle bits of the LCG
    function automatic word_t randImm();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {{21{lcgState[20]}}, lcgState[20:10]};
    endfunction

    function automatic inst_t encR(input logic [6:0] f7, input logic [2:0] f3,
                                   input regIdx_t rd, input regIdx_t rs1, input regIdx_t rs2);
        return {f7, rs2, rs1, f3, rd, `OP_RTYPE};
    endfunction

    function automatic inst_t encI(input logic [6:0] op, input logic [2:0] f3,
                                   input regIdx_t rd, input regIdx_t rs1, input word_t imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic inst_t encS(input regIdx_t rs2, input regIdx_t rs1, input word_t imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
    endfunction

    function automatic inst_t encB(input regIdx_t rs1, input regIdx_t rs2, input word_t imm);
        return {imm[12], imm[10:5], rs2, rs1, `F3_ADD, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    task automatic emit(input inst_t w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic emitAddi(input regIdx_t rd, input regIdx_t rs1, input word_t imm);
        emit(encI(`OP_ITYPE, `F3_ADD, rd, rs1, imm));
    endtask

    task automatic addRow(input logic [127:0] name, input regIdx_t rd, input word_t exp);
        rowName[numRows] = name;
        for (int w = 0; w < MaxWords; w++) begin
            rowProg[numRows][w] = prog[w];
        end
        rowLen[numRows] = progLen;
        rowReg[numRows] = rd;
        rowExp[numRows] = exp;
        rowRun[numRows] = progLen + 4; // Slack spent on the self-loop
        numRows++;
    endtask

    task automatic buildTable();
        word_t a;
        word_t b;
        a = randImm();
        b = randImm();
        progLen = 0;
        emitAddi(1, 0, a);
        emitAddi(2, 0, b);
        emit(encR(7'b0000000, `F3_ADD, 3, 1, 2));
        emit(encR(7'b0100000, `F3_ADD, 4, 1, 2)); // SUB
        emit(LoopWord);
        addRow("add", 3, a + b);
        addRow("sub", 4, a - b);

        a = randImm() | 32'hFFFF_FC00; // Forced negative
        b = randImm() & 32'h0000_03FF; // Forced non-negative
        progLen = 0;
        emitAddi(1, 0, a);
        emitAddi(2, 0, b);
        emit(encR(7'b0000000, `F3_AND, 3, 1, 2));
        emit(encR(7'b0000000, `F3_OR, 4, 1, 2));
        emit(encR(7'b0000000, `F3_SLT, 5, 1, 2));
        emit(encR(7'b0000000, `F3_SLT, 6, 2, 1));
        emit(LoopWord);
        addRow("and", 3, a & b);
        addRow("or", 4, a | b);
        addRow("sltNeg", 5, 32'd1); // Negative is below non-negative
        addRow("sltPos", 6, 32'd0);

        a = randImm();
        b = randImm();
        if (b == a) begin
            b = b ^ 32'd1;
        end
        progLen = 0;
        emitAddi(1, 0, a);
        emitAddi(2, 0, b);
        emit(encS(1, 0, 8));
        emit(encS(2, 0, 12));
        emit(encI(`OP_LOAD, 3'b010, 3, 0, 8));
        emit(encI(`OP_LOAD, 3'b010, 4, 0, 12));
        emit(LoopWord);
        addRow("lwFirst", 3, a);
        addRow("lwSecond", 4, b);

        a = randImm();
        if (a == 0) begin
            a = 1;
        end
        progLen = 0;
        emitAddi(3, 0, 11);
        emitAddi(4, 0, 0);
        emitAddi(1, 0, a);
        emit(encB(1, 1, 8)); // Taken branch skips the next word
        emitAddi(3, 0, 99);
        emit(encB(1, 0, 8)); // Falls through because x1 is nonzero
        emitAddi(4, 0, 44);
        emit(LoopWord);
        addRow("beqTaken", 3, 11);
        addRow("beqNotTaken", 4, 44);

        progLen = 0;
        emitAddi(0, 0, randImm() | 32'd1);
        emit(LoopWord);
        addRow("x0Write", 0, 0);

        progLen = 0;
        emitAddi(7, 0, 1);
        for (int i = 0; i < 6; i++) begin
            emitAddi(7, 7, 1);
        end
        emit(LoopWord);
        addRow("longProg", 7, 7);

        a = randImm();
        if (a == 7) begin
            a = 8;
        end
        progLen = 0;
        emitAddi(7, 0, a);
        emit(LoopWord);
        addRow("shortProg", 7, a);
    endtask

    // Starts and ends on a falling edge
    task automatic runRow(input int r);
        run = 1'b0;
        for (int w = 0; w < rowLen[r]; w++) begin
            imemWe   = 1'b1;
            imemAddr = imemAddr_t'(w);
            imemData = rowProg[r][w];
            @(negedge CLK);
        end
        imemWe = 1'b0;
        run    = 1'b1;
        repeat (rowRun[r]) @(negedge CLK);
        run       = 1'b0;
        dbgReg    = rowReg[r];
        checkName = rowName[r];
        checkExp  = rowExp[r];
        checkReq  = 1'b1;
        @(negedge CLK);
        checkReq = 1'b0;
    endtask

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        rstN      = 1'b0;
        run       = 1'b0;
        imemWe    = 1'b0;
        imemAddr  = '0;
        imemData  = '0;
        dbgReg    = '0;
        checkReq  = 1'b0;
        checkName = '0;
        checkExp  = '0;
        lcgState  = 32'h15db_d29c;
        numRows   = 0;
        buildTable();

        cycleLimit = 2 + 20; // Reset plus margin
        for (int r = 0; r < numRows; r++) begin
            cycleLimit += rowLen[r] + rowRun[r] + 1;
        end

        repeat (2) @(negedge CLK);
        rstN = 1'b1;
        for (int r = 0; r < numRows; r++) begin
            runRow(r);
        end

        $display("Tests done: %0d passed, %0d failed", passCount, failCount);
        if (passCount + failCount != numRows) begin
            $display("Checker saw %0d of %0d tests", passCount + failCount, numRows);
        end
        if (failCount == 0 && passCount == numRows) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
cpuPkg.sv
fetchUnit.sv
decodeUnit.sv
executeUnit.sv
resultUnit.sv
singleCpu.sv
tbClock.sv
tbChecker.sv
tbSingleCpu.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tbSingleCpu -f flist.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi

if ! grep -q "STATUS: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi

exit 0
